// File: include/sparse_defs.svh
`ifndef SPARSE_DEFS_SVH
`define SPARSE_DEFS_SVH

// ========================================
// Datapath geometry
// ========================================

// Clusters per MAC word
`define TRANSFER_SIZE 4
`define LOG2_TRANSFER_SIZE 2
// Bits in one compression window
`define WINDOW_SIZE 16
`define LOG2_WINDOW_SIZE 4
`define CLUSTER_BITWIDTH 8

// ========================================
// Wishbone port
// ========================================

`define WB_DATA_WIDTH 32
// Word index, not a byte address
`define WB_ADDR_WIDTH 3

// Register map
`define ADDR_WINDOW 3'd0
`define ADDR_START 3'd1
`define ADDR_TRANSFER 3'd2
`define ADDR_MAC 3'd3
`define ADDR_STATUS 3'd4
`define ADDR_BUFFER 3'd5

`endif

// File: source/sparsePkg.sv
`default_nettype none

`include "sparse_defs.svh"

package sparsePkg;

	// One weight cluster
	typedef logic [`CLUSTER_BITWIDTH-1:0] cluster_t;

	// Cluster 0 sits in the low byte
	typedef cluster_t [`TRANSFER_SIZE-1:0] clusterBlock_t;

	// Window and transfer bitmasks, LSB first
	typedef logic [`WINDOW_SIZE-1:0] windowMask_t;
	typedef logic [`TRANSFER_SIZE-1:0] transferMask_t;

	// Position in a window, 0 to 16
	// 16 means the window is used up
	typedef logic [`LOG2_WINDOW_SIZE:0] windowIndex_t;

	// Number of dense clusters in one transfer, 0 to 4
	typedef logic [`LOG2_TRANSFER_SIZE:0] clusterCount_t;

	// Clusters held back between transfers, 0 to 3
	typedef logic [`LOG2_TRANSFER_SIZE-1:0] bufferSize_t;

endpackage

`default_nettype wire

// File: source/wbPkg.sv
`default_nettype none

`include "sparse_defs.svh"

package wbPkg;

	typedef logic [`WB_DATA_WIDTH-1:0] wbData_t;
	typedef logic [`WB_ADDR_WIDTH-1:0] wbAddr_t;

	// WINDOW write layout
	typedef struct packed {
		sparsePkg::windowMask_t mutualMask;
		sparsePkg::windowMask_t windowMask;
	} maskPair_t;

	// A written word seen either as two masks or as four clusters
	typedef union packed {
		maskPair_t masks;
		sparsePkg::clusterBlock_t clusters;
	} wbWord_u;

	// Bits of STATUS that carry information
	localparam int statusUsedBits = `TRANSFER_SIZE + `LOG2_WINDOW_SIZE + 1
		+ `LOG2_TRANSFER_SIZE + 1;

	// STATUS read word, transfer mask in the low bits
	typedef struct packed {
		logic [`WB_DATA_WIDTH-statusUsedBits-1:0] reserved;
		logic macValid;
		sparsePkg::bufferSize_t bufferSize;
		sparsePkg::windowIndex_t nextStartIndex;
		sparsePkg::transferMask_t transferMask;
	} status_t;

endpackage

`default_nettype wire

// File: source/maskPrefixCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module maskPrefixCounter #(
	parameter int maskLength = `WINDOW_SIZE
) (
	input wire logic [maskLength-1:0] mask,
	input wire sparsePkg::windowIndex_t startIndex,
	output sparsePkg::windowIndex_t [maskLength-1:0] prefixCount
);

	sparsePkg::windowIndex_t running;

	// Walk the mask from the LSB up
	// Bits below the start index are skipped, so those positions read zero
	always_comb begin
		running = '0;
		for (int i = 0; i < maskLength; i++) begin
			if (sparsePkg::windowIndex_t'(i) >= startIndex) begin
				running = running + sparsePkg::windowIndex_t'(mask[i]);
			end
			// Count includes the bit at this position
			prefixCount[i] = running;
		end
	end

endmodule

`default_nettype wire

// File: source/windowFilter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module windowFilter (
	input wire sparsePkg::windowMask_t windowMask,
	input wire sparsePkg::windowMask_t mutualMask,
	input wire sparsePkg::windowIndex_t startIndex,
	output sparsePkg::transferMask_t packedMask,
	output sparsePkg::windowIndex_t nextStartIndex
);

	// Rank of every window position, counted from the start index
	sparsePkg::windowIndex_t [`WINDOW_SIZE-1:0] rank;

	maskPrefixCounter #(
		.maskLength(`WINDOW_SIZE)
	) rankCounter (
		.mask(windowMask),
		.startIndex(startIndex),
		.prefixCount(rank)
	);

	// ========================================
	// Pack mutual bits by rank
	// ========================================

	// Only set window bits carry a rank
	// Unset bits repeat the rank of the bit before them
	always_comb begin
		packedMask = '0;
		nextStartIndex = sparsePkg::windowIndex_t'(`WINDOW_SIZE);
		for (int p = 0; p < `WINDOW_SIZE; p++) begin
			if (windowMask[p]) begin
				for (int k = 0; k < `TRANSFER_SIZE; k++) begin
					if (rank[p] == sparsePkg::windowIndex_t'(k + 1)) begin
						packedMask[k] = mutualMask[p];
					end
				end
				// Next window starts right after the last packed bit
				if (rank[p] == sparsePkg::windowIndex_t'(`TRANSFER_SIZE)) begin
					nextStartIndex = sparsePkg::windowIndex_t'(p + 1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/clusterCompactor.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module clusterCompactor (
	input wire sparsePkg::transferMask_t selectMask,
	input wire sparsePkg::clusterBlock_t transferBlock,
	output sparsePkg::clusterBlock_t denseClusters,
	output sparsePkg::clusterCount_t denseCount
);

	sparsePkg::windowIndex_t [`TRANSFER_SIZE-1:0] rank;

	// Ranks over the whole block
	maskPrefixCounter #(
		.maskLength(`TRANSFER_SIZE)
	) rankCounter (
		.mask(selectMask),
		.startIndex(sparsePkg::windowIndex_t'(0)),
		.prefixCount(rank)
	);

	// Last position holds the total
	assign denseCount = sparsePkg::clusterCount_t'(rank[`TRANSFER_SIZE-1]);

	// Selected cluster of rank k+1 lands in dense slot k
	always_comb begin
		denseClusters = '0;
		for (int p = 0; p < `TRANSFER_SIZE; p++) begin
			if (selectMask[p]) begin
				for (int k = 0; k < `TRANSFER_SIZE; k++) begin
					if (rank[p] == sparsePkg::windowIndex_t'(k + 1)) begin
						denseClusters[k] = transferBlock[p];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/clusterBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module clusterBuffer (
	input wire logic clock,
	input wire logic reset,
	input wire logic transferLoad,
	input wire logic macRead,
	input wire sparsePkg::clusterBlock_t denseClusters,
	input wire sparsePkg::clusterCount_t denseCount,
	output sparsePkg::clusterBlock_t macWord,
	output logic macValid,
	output sparsePkg::clusterBlock_t bufferWord,
	output sparsePkg::bufferSize_t bufferSize
);

	// Held clusters followed by the new dense ones
	sparsePkg::cluster_t [2*`TRANSFER_SIZE-1:0] merged;
	sparsePkg::clusterCount_t totalCount;
	logic wordFormed;

	assign totalCount = sparsePkg::clusterCount_t'(bufferSize) + denseCount;
	assign wordFormed = totalCount >= sparsePkg::clusterCount_t'(`TRANSFER_SIZE);

	// ========================================
	// Merge
	// ========================================

	always_comb begin
		sparsePkg::clusterCount_t slot;
		merged = '0;
		for (int i = 0; i < `TRANSFER_SIZE; i++) begin
			if (sparsePkg::bufferSize_t'(i) < bufferSize) begin
				merged[i] = bufferWord[i];
			end
		end
		// Dense clusters start right after the last held one
		for (int j = 0; j < `TRANSFER_SIZE; j++) begin
			slot = sparsePkg::clusterCount_t'(j) + sparsePkg::clusterCount_t'(bufferSize);
			if (sparsePkg::clusterCount_t'(j) < denseCount) begin
				merged[slot] = denseClusters[j];
			end
		end
	end

	// ========================================
	// Buffer and MAC word registers
	// ========================================

	always_ff @(posedge clock) begin
		if (reset) begin
			bufferWord <= '0;
			bufferSize <= '0;
			macWord <= '0;
			macValid <= 1'b0;
		end else begin
			if (transferLoad) begin
				if (wordFormed) begin
					macWord <= merged[`TRANSFER_SIZE-1:0];
					bufferWord <= merged[2*`TRANSFER_SIZE-1:`TRANSFER_SIZE];
					bufferSize <= sparsePkg::bufferSize_t'(totalCount
						- sparsePkg::clusterCount_t'(`TRANSFER_SIZE));
				end else begin
					bufferWord <= merged[`TRANSFER_SIZE-1:0];
					bufferSize <= sparsePkg::bufferSize_t'(totalCount);
				end
			end
			// A fresh MAC word beats a clearing read in the same cycle
			if (transferLoad && wordFormed) begin
				macValid <= 1'b1;
			end else if (macRead) begin
				macValid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/wbSlavePort.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module wbSlavePort (
	input wire logic clock,
	input wire logic reset,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire wbPkg::wbAddr_t wbAdr,
	input wire wbPkg::wbData_t wbDatIn,
	input wire sparsePkg::transferMask_t packedMask,
	input wire sparsePkg::windowIndex_t nextStartIndex,
	input wire sparsePkg::clusterBlock_t macWord,
	input wire logic macValid,
	input wire sparsePkg::clusterBlock_t bufferWord,
	input wire sparsePkg::bufferSize_t bufferSize,
	output wbPkg::wbData_t wbDatOut,
	output logic wbAck,
	output sparsePkg::windowMask_t windowMask,
	output sparsePkg::windowMask_t mutualMask,
	output sparsePkg::windowIndex_t startIndex,
	output sparsePkg::transferMask_t selectMask,
	output sparsePkg::clusterBlock_t transferBlock,
	output logic startLoad,
	output logic transferLoad,
	output logic macRead
);

	logic request;
	logic writeRequest;
	logic readRequest;
	logic windowLoad;
	logic filterCapture;
	sparsePkg::windowIndex_t heldNextStart;
	wbPkg::wbWord_u writeWord;
	wbPkg::status_t status;
	wbPkg::wbData_t readData;

	// ========================================
	// Handshake and address decode
	// ========================================

	// Masked during the ack cycle, so each request costs one wait state
	assign request = wbCyc && wbStb && !wbAck;
	assign writeRequest = request && wbWe;
	assign readRequest = request && !wbWe;

	assign windowLoad = writeRequest && (wbAdr == `ADDR_WINDOW);
	assign startLoad = writeRequest && (wbAdr == `ADDR_START);
	assign transferLoad = writeRequest && (wbAdr == `ADDR_TRANSFER);
	assign macRead = readRequest && (wbAdr == `ADDR_MAC);

	assign writeWord = wbDatIn;
	assign transferBlock = writeWord.clusters;

	always_ff @(posedge clock) begin
		if (reset) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= request;
		end
	end

	// ========================================
	// Window registers
	// ========================================

	always_ff @(posedge clock) begin
		if (reset) begin
			windowMask <= '0;
			mutualMask <= '0;
			startIndex <= '0;
		end else begin
			if (windowLoad) begin
				windowMask <= writeWord.masks.windowMask;
				mutualMask <= writeWord.masks.mutualMask;
			end
			if (startLoad) begin
				startIndex <= wbDatIn[`LOG2_WINDOW_SIZE:0];
			end
		end
	end

	// Filter sees the new start index one edge after the write
	always_ff @(posedge clock) begin
		if (reset) begin
			filterCapture <= 1'b0;
			selectMask <= '0;
			heldNextStart <= '0;
		end else begin
			filterCapture <= startLoad;
			if (filterCapture) begin
				selectMask <= packedMask;
				heldNextStart <= nextStartIndex;
			end
		end
	end

	// ========================================
	// Read path
	// ========================================

	always_comb begin
		status = '0;
		status.transferMask = selectMask;
		status.nextStartIndex = heldNextStart;
		status.bufferSize = bufferSize;
		status.macValid = macValid;
		case (wbAdr)
			`ADDR_MAC: readData = macWord;
			`ADDR_STATUS: readData = status;
			`ADDR_BUFFER: readData = bufferWord;
			// Write-only and unmapped words read zero
			default: readData = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wbDatOut <= '0;
		end else if (readRequest) begin
			wbDatOut <= readData;
		end
	end

endmodule

`default_nettype wire

// File: source/sparseMacTop.sv
`timescale 1ns/1ps
`default_nettype none

module sparseMacTop (
	input wire logic clock,
	input wire logic reset,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire wbPkg::wbAddr_t wbAdr,
	input wire wbPkg::wbData_t wbDatIn,
	output wbPkg::wbData_t wbDatOut,
	output logic wbAck
);

	sparsePkg::windowMask_t windowMask;
	sparsePkg::windowMask_t mutualMask;
	sparsePkg::windowIndex_t startIndex;
	sparsePkg::transferMask_t packedMask;
	sparsePkg::windowIndex_t nextStartIndex;
	sparsePkg::transferMask_t selectMask;
	sparsePkg::clusterBlock_t transferBlock;
	sparsePkg::clusterBlock_t denseClusters;
	sparsePkg::clusterCount_t denseCount;
	sparsePkg::clusterBlock_t macWord;
	sparsePkg::clusterBlock_t bufferWord;
	sparsePkg::bufferSize_t bufferSize;
	logic macValid;
	logic startLoad;
	logic transferLoad;
	logic macRead;

	wbSlavePort slavePort (
		.clock(clock), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatIn(wbDatIn),
		.packedMask(packedMask), .nextStartIndex(nextStartIndex),
		.macWord(macWord), .macValid(macValid),
		.bufferWord(bufferWord), .bufferSize(bufferSize),
		.wbDatOut(wbDatOut), .wbAck(wbAck),
		.windowMask(windowMask), .mutualMask(mutualMask), .startIndex(startIndex),
		.selectMask(selectMask), .transferBlock(transferBlock),
		.startLoad(startLoad), .transferLoad(transferLoad), .macRead(macRead)
	);

	// Filter, then compactor, then buffer
	windowFilter filter (
		.windowMask(windowMask), .mutualMask(mutualMask), .startIndex(startIndex),
		.packedMask(packedMask), .nextStartIndex(nextStartIndex)
	);

	clusterCompactor compactor (
		.selectMask(selectMask), .transferBlock(transferBlock),
		.denseClusters(denseClusters), .denseCount(denseCount)
	);

	clusterBuffer mergeBuffer (
		.clock(clock), .reset(reset),
		.transferLoad(transferLoad), .macRead(macRead),
		.denseClusters(denseClusters), .denseCount(denseCount),
		.macWord(macWord), .macValid(macValid),
		.bufferWord(bufferWord), .bufferSize(bufferSize)
	);

endmodule

`default_nettype wire

// File: verification/sparseMac_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module sparseMac_chk (
	input wire logic clock,
	input wire logic reset,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbAck,
	input wire logic transferLoad,
	input wire logic macValid,
	input wire sparsePkg::clusterCount_t denseCount,
	input wire sparsePkg::bufferSize_t bufferSize
);

	// Acknowledge is a single-cycle pulse
	ackSinglePulse: assert property (@(posedge clock) disable iff (reset)
		wbAck |=> !wbAck)
		else $error("wbAck stayed high for more than one cycle");

	// Every acknowledge answers a request seen one edge earlier
	ackAfterRequest: assert property (@(posedge clock) disable iff (reset)
		wbAck |-> $past(wbCyc && wbStb && !wbAck))
		else $error("wbAck rose without a pending request");

	macValidAfterReset: assert property (@(posedge clock)
		reset |=> !macValid)
		else $error("macValid set right after reset");

	// Clusters left after a transfer never fill a whole MAC word
	bufferSizeRange: assert property (@(posedge clock) disable iff (reset)
		transferLoad |=> int'(bufferSize)
			== (int'($past(bufferSize)) + int'($past(denseCount))) % `TRANSFER_SIZE)
		else $error("bufferSize does not match the clusters left over");

endmodule

bind sparseMacTop sparseMac_chk protocolChecks (
	.clock(clock), .reset(reset),
	.wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
	.transferLoad(transferLoad), .macValid(macValid),
	.denseCount(denseCount), .bufferSize(bufferSize)
);

`default_nettype wire

// File: verification/sparseMacTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_defs.svh"

module sparseMacTb;

	localparam int randomFilterCases = 200;
	localparam int mergeSteps = 60;
	localparam int ackLimit = 8;
	// Upper bound on bus transactions, section by section
	localparam int totalTransactions = 3 + 3 * 3 + randomFilterCases * 3 + 16 * 6
		+ mergeSteps * 8 + 14;
	localparam int watchdogCycles = totalTransactions * 4 + 200;

	logic clock;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [`WB_ADDR_WIDTH-1:0] wbAdr;
	logic [`WB_DATA_WIDTH-1:0] wbDatIn;
	logic [`WB_DATA_WIDTH-1:0] wbDatOut;
	logic wbAck;

	// Reference model state
	logic [15:0] modelWindow;
	logic [15:0] modelMutual;
	logic [4:0] modelStart;
	logic [3:0] modelSel;
	logic [4:0] modelNext;
	logic [7:0] modelHeld[$];
	logic [31:0] modelMac;
	logic modelValid;

	// Reads waiting for comparison
	logic [31:0] expectedQ[$];
	logic [31:0] actualQ[$];
	string nameQ[$];
	logic [31:0] cmpExpected;
	logic [31:0] cmpActual;
	string cmpName;
	int checksFailed;

	sparseMacTop dut_i (
		.clock(clock), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatIn(wbDatIn),
		.wbDatOut(wbDatOut), .wbAck(wbAck)
	);

	always #10 clock = ~clock;

	// ========================================
	// Reference model
	// ========================================

	// Returns {next start index, packed mask}
	function automatic logic [8:0] refFilter(input logic [15:0] wm, input logic [15:0] mm,
			input logic [4:0] start);
		logic [3:0] packedBits;
		logic [4:0] nextIndex;
		int rank;
		packedBits = '0;
		nextIndex = 5'd16;
		rank = 0;
		for (int p = int'(start); p < 16; p++) begin
			if (wm[p]) begin
				rank++;
				if (rank <= 4) begin
					packedBits[rank-1] = mm[p];
				end
				if (rank == 4) begin
					nextIndex = 5'(p + 1);
				end
			end
		end
		return {nextIndex, packedBits};
	endfunction

	// Compact the selected clusters and merge them into the held buffer
	function automatic void refTransfer(input logic [3:0] sel, input logic [31:0] block);
		logic [7:0] dropped;
		for (int p = 0; p < 4; p++) begin
			if (sel[p]) begin
				modelHeld.push_back(block[8*p +: 8]);
			end
		end
		if (modelHeld.size() >= 4) begin
			modelMac = {modelHeld[3], modelHeld[2], modelHeld[1], modelHeld[0]};
			modelValid = 1'b1;
			for (int i = 0; i < 4; i++) begin
				dropped = modelHeld.pop_front();
			end
		end
	endfunction

	function automatic logic [31:0] refStatus();
		logic [31:0] word;
		word = '0;
		word[3:0] = modelSel;
		word[8:4] = modelNext;
		word[10:9] = 2'(modelHeld.size());
		word[11] = modelValid;
		return word;
	endfunction

	// Unused slots read zero
	function automatic logic [31:0] refBufferWord();
		logic [31:0] word;
		word = '0;
		for (int i = 0; i < modelHeld.size(); i++) begin
			word[8*i +: 8] = modelHeld[i];
		end
		return word;
	endfunction

	function automatic void resetModel();
		modelWindow = '0;
		modelMutual = '0;
		modelStart = '0;
		modelSel = '0;
		modelNext = '0;
		modelHeld.delete();
		modelMac = '0;
		modelValid = 1'b0;
	endfunction

	// ========================================
	// Bus tasks
	// ========================================

	task automatic busAccess(input logic write, input logic [2:0] addr,
			input logic [31:0] data, output logic [31:0] readData);
		int waitCycles;
		@(negedge clock);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = write;
		wbAdr = addr;
		wbDatIn = data;
		waitCycles = 0;
		do begin
			@(negedge clock);
			waitCycles++;
		end while (!wbAck && waitCycles < ackLimit);
		if (!wbAck) begin
			$display("Bus access to address %0d was never acknowledged (t=%0t)", addr, $time);
			$display("Errors found");
			$fatal(1, "Missing acknowledge");
		end else begin
			readData = wbDatOut;
			wbCyc = 1'b0;
			wbStb = 1'b0;
			wbWe = 1'b0;
		end
	endtask

	task automatic busWrite(input logic [2:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		busAccess(1'b1, addr, data, ignored);
	endtask

	task automatic readCheck(input logic [2:0] addr, input logic [31:0] expected,
			input string name);
		logic [31:0] actual;
		busAccess(1'b0, addr, '0, actual);
		expectedQ.push_back(expected);
		actualQ.push_back(actual);
		nameQ.push_back(name);
	endtask

	task automatic writeWindow(input logic [15:0] wm, input logic [15:0] mm);
		busWrite(`ADDR_WINDOW, {mm, wm});
		modelWindow = wm;
		modelMutual = mm;
	endtask

	task automatic writeStart(input logic [4:0] start);
		busWrite(`ADDR_START, 32'(start));
		modelStart = start;
		{modelNext, modelSel} = refFilter(modelWindow, modelMutual, modelStart);
	endtask

	task automatic writeTransfer(input logic [31:0] block);
		busWrite(`ADDR_TRANSFER, block);
		refTransfer(modelSel, block);
	endtask

	// A MAC read clears the valid flag
	task automatic readMac();
		readCheck(`ADDR_MAC, modelMac, "wbDatOut (MAC)");
		modelValid = 1'b0;
	endtask

	task automatic applyReset();
		@(negedge clock);
		reset = 1'b1;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		resetModel();
	endtask

	// Compare process
	always @(posedge clock) begin
		while (actualQ.size() > 0) begin
			cmpName = nameQ.pop_front();
			cmpExpected = expectedQ.pop_front();
			cmpActual = actualQ.pop_front();
			assert (cmpActual === cmpExpected)
			else begin
				checksFailed++;
				$display("[FAIL] t=%0t %s expected %h actual %h", $time, cmpName,
					cmpExpected, cmpActual);
				$display("Errors found");
				$fatal(1, "Read mismatch");
			end
		end
	end

	// Watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clock);
		$display("Run timed out after %0d cycles before the tests finished", watchdogCycles);
		$display("Errors found");
		$fatal(1, "Watchdog expired");
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [31:0] block;
		logic [15:0] wm;
		void'($urandom(32'h228c));
		clock = 1'b0;
		reset = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		checksFailed = 0;
		resetModel();
		repeat (5) @(negedge clock);
		reset = 1'b0;

		// Reset values
		readCheck(`ADDR_STATUS, 32'h0, "wbDatOut (STATUS)");
		readCheck(`ADDR_MAC, 32'h0, "wbDatOut (MAC)");
		readCheck(`ADDR_BUFFER, 32'h0, "wbDatOut (BUFFER)");

		// Directed windows: full, empty, start past the last set bit
		writeWindow(16'hFFFF, 16'hA5C3);
		writeStart(5'd3);
		readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
		writeWindow(16'h0000, 16'hFFFF);
		writeStart(5'd0);
		readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
		writeWindow(16'h00F0, 16'h00B0);
		writeStart(5'd9);
		readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");

		for (int i = 0; i < randomFilterCases; i++) begin
			wm = 16'($urandom);
			// Thin out every other window so sparse ones show up too
			if (i % 2 == 1) begin
				wm = wm & 16'($urandom);
			end
			writeWindow(wm, 16'($urandom));
			writeStart(5'($urandom_range(0, 16)));
			readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
		end

		// Every select mask from an empty buffer
		for (int sel = 0; sel < 16; sel++) begin
			applyReset();
			// First four window bits set, so the mutual mask passes straight through
			writeWindow(16'h000F, 16'(sel));
			writeStart(5'd0);
			writeTransfer($urandom | 32'h01010101);
			readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
			readCheck(`ADDR_BUFFER, refBufferWord(), "wbDatOut (BUFFER)");
			readMac();
		end

		// Random transfer streams
		applyReset();
		for (int step = 0; step < mergeSteps; step++) begin
			writeWindow(16'($urandom), 16'($urandom));
			writeStart(5'($urandom_range(0, 8)));
			readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
			writeTransfer($urandom);
			readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
			readCheck(`ADDR_BUFFER, refBufferWord(), "wbDatOut (BUFFER)");
			if ($urandom_range(0, 1) == 1) begin
				readMac();
				readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
			end
		end

		// Unmapped and read-only addresses
		block = $urandom;
		busWrite(3'd6, block);
		busWrite(3'd7, ~block);
		busWrite(`ADDR_MAC, block);
		busWrite(`ADDR_STATUS, block);
		readCheck(3'd6, 32'h0, "wbDatOut (address 6)");
		readCheck(3'd7, 32'h0, "wbDatOut (address 7)");
		readCheck(`ADDR_WINDOW, 32'h0, "wbDatOut (WINDOW)");
		readCheck(`ADDR_START, 32'h0, "wbDatOut (START)");
		readCheck(`ADDR_TRANSFER, 32'h0, "wbDatOut (TRANSFER)");
		readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");
		readCheck(`ADDR_BUFFER, refBufferWord(), "wbDatOut (BUFFER)");
		// Window registers must still hold the last masks
		writeStart(modelStart);
		readCheck(`ADDR_STATUS, refStatus(), "wbDatOut (STATUS)");

		repeat (3) @(posedge clock);
		if (checksFailed == 0 && actualQ.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "Checks failed");
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
source/sparsePkg.sv
source/wbPkg.sv
source/maskPrefixCounter.sv
source/windowFilter.sv
source/clusterCompactor.sv
source/clusterBuffer.sv
source/wbSlavePort.sv
source/sparseMacTop.sv
verification/sparseMac_chk.sv
verification/sparseMacTb.sv

// File: Makefile
VERILATOR := verilator
FLAGS := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP := sparseMacTb
FILELIST := tb.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
